// ==== run.sh ====
#!/bin/sh
# build and run the RV64I execute testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module rv_exec_tb -o rv_exec_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/rv_exec_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
fi

if grep -qx "NO ERRORS" sim.log; then
  exit 0
fi
exit 1

// ==== rv_exec_chk.sv ====
`timescale 1ns/1ps

module rv_exec_chk (
  input logic clk,
  input logic rst_n_i,
  input logic req_i,
  input logic ack_i,
  input logic we_i
);

  // ack only follows a sampled request
  ack_rise_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    $rose(ack_i) |-> $past(req_i))
    else $error("ack rose without a pending request");

  // ack held for as long as req stays high
  ack_hold_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    (ack_i && req_i) |=> ack_i)
    else $error("ack dropped while req was still high");

  // single-cycle write strobe
  we_pulse_a: assert property (@(posedge clk) disable iff (!rst_n_i)
    we_i |=> !we_i)
    else $error("register write strobe lasted more than one cycle");

endmodule

// ==== rv_exec_defines.svh ====
`ifndef RV_EXEC_DEFINES_SVH
`define RV_EXEC_DEFINES_SVH

// machine width and register file size
`define RV_XLEN      64
`define RV_NREG      32
`define RV_RESET_PC  64'h0000_0000_8000_0000

// major opcodes
`define RV_OPC_OP      7'b0110011
`define RV_OPC_OPIMM   7'b0010011
`define RV_OPC_LUI     7'b0110111
`define RV_OPC_AUIPC   7'b0010111
`define RV_OPC_JAL     7'b1101111
`define RV_OPC_JALR    7'b1100111
`define RV_OPC_BRANCH  7'b1100011
`define RV_OPC_SYSTEM  7'b1110011

// funct3 of the OP and OP-IMM groups
`define RV_F3_ADD   3'b000
`define RV_F3_SLL   3'b001
`define RV_F3_SLT   3'b010
`define RV_F3_SLTU  3'b011
`define RV_F3_XOR   3'b100
`define RV_F3_SR    3'b101
`define RV_F3_OR    3'b110
`define RV_F3_AND   3'b111

// funct3 of the branches
`define RV_F3_BEQ   3'b000
`define RV_F3_BNE   3'b001
`define RV_F3_BLT   3'b100
`define RV_F3_BGE   3'b101
`define RV_F3_BLTU  3'b110
`define RV_F3_BGEU  3'b111

`define RV_F7_BASE       7'b0000000
`define RV_F7_ALT        7'b0100000
`define RV_INSTR_EBREAK  32'h0010_0073

`endif

// ==== rv_exec_pkg.sv ====
`include "rv_exec_defines.svh"

package rv_exec_pkg;

  typedef logic [`RV_XLEN-1:0]         xlen_t;
  typedef logic [$clog2(`RV_NREG)-1:0] reg_idx_t;
  typedef logic [31:0]                 instr_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_op2
  } alu_op_e;

  typedef enum logic [3:0] {
    bjp_none,
    bjp_jal,
    bjp_jalr,
    bjp_beq,
    bjp_bne,
    bjp_blt,
    bjp_bge,
    bjp_bltu,
    bjp_bgeu
  } bjp_op_e;

  typedef enum logic [1:0] {
    trap_none,
    trap_ebreak,
    trap_illegal
  } trap_e;

  typedef enum logic {
    ctrl_idle,
    ctrl_ack
  } ctrl_state_e;

  // decoder to execute unit
  typedef struct packed {
    alu_op_e  alu_op;
    bjp_op_e  bjp_op;
    xlen_t    op1;
    xlen_t    op2;
    xlen_t    jp_op1;
    xlen_t    jp_op2;
    reg_idx_t rd;
    logic     rd_we;
    xlen_t    link_pc;
  } exu_req_t;

  typedef struct packed {
    reg_idx_t rd;
    logic     rd_we;
    xlen_t    rd_data;
    logic     jump_taken;
    xlen_t    jump_addr;
  } exu_res_t;

  // one report per retired instruction
  typedef struct packed {
    xlen_t    pc;
    reg_idx_t rd;
    logic     rd_we;
    xlen_t    rd_data;
    xlen_t    next_pc;
    trap_e    trap;
  } retire_t;

endpackage

// ==== rv_exec_tb.sv ====
`timescale 1ns/1ps
`include "rv_exec_defines.svh"

module rv_exec_tb;
  import rv_exec_pkg::*;

  localparam int RST_CYCLES = 10;
  // transactions per group
  localparam int N_RST_READ = 31;
  localparam int N_SEED     = 31 * 3;
  localparam int N_ALU      = 120;
  localparam int N_UPPER    = 20;
  localparam int N_BR       = 4 + 24;
  localparam int N_JMP      = 16;
  localparam int N_TRAP     = 24;
  localparam int NUM_TXN    = N_RST_READ + N_SEED + N_ALU + N_UPPER + N_BR + N_JMP + N_TRAP;
  localparam int TIMEOUT_CYCLES = RST_CYCLES + 8 * NUM_TXN;

  logic    clk;
  logic    rst_n;
  logic    req;
  instr_t  instr;
  logic    ack;
  retire_t retire;

  // reference model state
  xlen_t   model_regs [32];
  xlen_t   model_pc;
  retire_t exp_q [$];
  retire_t act_q [$];
  string   name_q [$];
  retire_t last_ret;
  retire_t cmp_exp;
  retire_t cmp_act;
  string   cmp_name;
  int      cycle_cnt = 0;

  tb_clkgen u_tb_clkgen (
    .clk_o (clk)
  );

  rv_exec_top u_rv_exec_top (
    .clk      (clk),
    .rst_n_i  (rst_n),
    .req_i    (req),
    .instr_i  (instr),
    .ack_o    (ack),
    .retire_o (retire)
  );

  bind rv_issue_ctrl rv_exec_chk u_rv_exec_chk (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .req_i   (req_i),
    .ack_i   (ack_o),
    .we_i    (we_o)
  );

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("ERRORS FOUND");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_xlen(input string test, input string field, input xlen_t exp,
                            input xlen_t act);
    if (act !== exp) begin
      $display("Mismatch %s %s: expected %h, actual %h", test, field, exp, act);
      abort_run("wrong value in retire report");
    end
  endtask

  task automatic check_idx(input string test, input string field, input reg_idx_t exp,
                           input reg_idx_t act);
    if (act !== exp) begin
      $display("Mismatch %s %s: expected %0d, actual %0d", test, field, exp, act);
      abort_run("wrong register index in retire report");
    end
  endtask

  task automatic check_bit(input string test, input string field, input logic exp,
                           input logic act);
    if (act !== exp) begin
      $display("Mismatch %s %s: expected %b, actual %b", test, field, exp, act);
      abort_run("wrong flag value");
    end
  endtask

  task automatic check_trap(input string test, input string field, input trap_e exp,
                            input trap_e act);
    if (act !== exp) begin
      $display("Mismatch %s %s: expected %s, actual %s", test, field, exp.name(), act.name());
      abort_run("wrong trap in retire report");
    end
  endtask

  // ack and the report stay put while req is stretched
  task automatic check_held(input string test);
    check_bit(test, "held ack_o", 1'b1, ack);
    check_xlen(test, "held pc", last_ret.pc, retire.pc);
    check_idx(test, "held rd", last_ret.rd, retire.rd);
    check_bit(test, "held rd_we", last_ret.rd_we, retire.rd_we);
    check_xlen(test, "held rd_data", last_ret.rd_data, retire.rd_data);
    check_xlen(test, "held next_pc", last_ret.next_pc, retire.next_pc);
    check_trap(test, "held trap", last_ret.trap, retire.trap);
  endtask

  // instruction encoders
  function automatic instr_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                   input reg_idx_t rs1, input logic [2:0] f3,
                                   input reg_idx_t rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic instr_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                   input logic [2:0] f3, input reg_idx_t rd,
                                   input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic instr_t enc_j(input logic [20:0] imm, input reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OPC_JAL};
  endfunction

  function automatic instr_t enc_b(input logic [12:0] imm, input reg_idx_t rs2,
                                   input reg_idx_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OPC_BRANCH};
  endfunction

  // ISA semantics of the OP group, alt selects sub and sra
  function automatic xlen_t alu_ref(input logic [2:0] f3, input logic alt, input xlen_t x,
                                    input xlen_t y);
    case (f3)
      3'd0:    return alt ? (x - y) : (x + y);
      3'd1:    return x << y[5:0];
      3'd2:    return ($signed(x) < $signed(y)) ? xlen_t'(1) : '0;
      3'd3:    return (x < y) ? xlen_t'(1) : '0;
      3'd4:    return x ^ y;
      3'd5:    return alt ? xlen_t'($signed(x) >>> y[5:0]) : (x >> y[5:0]);
      3'd6:    return x | y;
      default: return x & y;
    endcase
  endfunction

  // executes one instruction on the model and returns the expected report
  function automatic retire_t ref_exec(input instr_t ins);
    retire_t    r;
    logic [2:0] f3;
    logic [6:0] f7;
    reg_idx_t   rd;
    xlen_t      a;
    xlen_t      b;
    xlen_t      imm_i;
    xlen_t      imm_u;
    xlen_t      val;
    xlen_t      target;
    logic       wr;
    logic       taken;
    trap_e      trap;
    f3     = ins[14:12];
    f7     = ins[31:25];
    rd     = ins[11:7];
    a      = model_regs[ins[19:15]];
    b      = model_regs[ins[24:20]];
    imm_i  = {{52{ins[31]}}, ins[31:20]};
    imm_u  = {{32{ins[31]}}, ins[31:12], 12'b0};
    val    = '0;
    target = '0;
    wr     = 1'b0;
    taken  = 1'b0;
    trap   = trap_none;
    case (ins[6:0])
      `RV_OPC_OP: begin
        wr = 1'b1;
        if (f7 == 7'h00) begin
          val = alu_ref(f3, 1'b0, a, b);
        end else if ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5))) begin
          val = alu_ref(f3, 1'b1, a, b);
        end else begin
          trap = trap_illegal;
        end
      end
      `RV_OPC_OPIMM: begin
        wr = 1'b1;
        if ((f3 == 3'd1) && (ins[31:26] != 6'b000000)) begin
          trap = trap_illegal;
        end else if ((f3 == 3'd5) && (ins[31:26] != 6'b000000) && (ins[31:26] != 6'b010000)) begin
          trap = trap_illegal;
        end else begin
          val = alu_ref(f3, (f3 == 3'd5) && ins[30], a, imm_i);
        end
      end
      `RV_OPC_LUI: begin
        wr  = 1'b1;
        val = imm_u;
      end
      `RV_OPC_AUIPC: begin
        wr  = 1'b1;
        val = model_pc + imm_u;
      end
      `RV_OPC_JAL: begin
        wr     = 1'b1;
        val    = model_pc + xlen_t'(4);
        taken  = 1'b1;
        target = model_pc + {{44{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      `RV_OPC_JALR: begin
        if (f3 != 3'd0) begin
          trap = trap_illegal;
        end else begin
          wr     = 1'b1;
          val    = model_pc + xlen_t'(4);
          taken  = 1'b1;
          target = (a + imm_i) & ~xlen_t'(1);
        end
      end
      `RV_OPC_BRANCH: begin
        target = model_pc + {{52{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        case (f3)
          3'd0:    taken = (a == b);
          3'd1:    taken = (a != b);
          3'd4:    taken = ($signed(a) < $signed(b));
          3'd5:    taken = ($signed(a) >= $signed(b));
          3'd6:    taken = (a < b);
          3'd7:    taken = (a >= b);
          default: trap = trap_illegal;
        endcase
      end
      `RV_OPC_SYSTEM: trap = (ins == `RV_INSTR_EBREAK) ? trap_ebreak : trap_illegal;
      default: trap = trap_illegal;
    endcase
    r.pc      = model_pc;
    r.rd      = rd;
    r.rd_we   = wr && (rd != '0) && (trap == trap_none);
    r.rd_data = r.rd_we ? val : '0;
    r.next_pc = (taken && (trap == trap_none)) ? target : model_pc + xlen_t'(4);
    r.trap    = trap;
    if (r.rd_we) begin
      model_regs[rd] = val;
    end
    model_pc = r.next_pc;
    return r;
  endfunction

  // one four-phase transaction
  task automatic run_instr(input string name, input instr_t ins);
    int hold;
    @(posedge clk);
    #1;
    instr = ins;
    req   = 1'b1;
    @(posedge clk);
    #1;
    while (!ack) begin
      @(posedge clk);
      #1;
    end
    last_ret = retire;
    exp_q.push_back(ref_exec(ins));
    act_q.push_back(retire);
    name_q.push_back(name);
    // some requests stay high a little longer as back-pressure
    hold = $urandom % 3;
    repeat (hold) begin
      @(posedge clk);
      #1;
      check_held(name);
    end
    req = 1'b0;
    @(posedge clk);
    #1;
    while (ack) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic test_reset_state();
    for (int i = 1; i < 32; i++) begin
      run_instr($sformatf("reset_read_x%0d", i),
                enc_r(7'h00, 5'd0, reg_idx_t'(i), 3'd0, reg_idx_t'(i), `RV_OPC_OP));
      if (i == 1) begin
        check_xlen("reset_state", "first pc", `RV_RESET_PC, last_ret.pc);
      end
    end
  endtask

  task automatic test_seed_regs();
    for (int i = 1; i < 32; i++) begin
      run_instr("seed_lui", {20'($urandom), reg_idx_t'(i), `RV_OPC_LUI});
      run_instr("seed_slli", enc_i(12'd32, reg_idx_t'(i), 3'd1, reg_idx_t'(i), `RV_OPC_OPIMM));
      run_instr("seed_xori", enc_i(12'($urandom), reg_idx_t'(i), 3'd4, reg_idx_t'(i),
                                   `RV_OPC_OPIMM));
    end
  endtask

  task automatic test_alu();
    logic [2:0]  f3;
    logic        alt;
    logic [5:0]  sh;
    logic [11:0] imm;
    reg_idx_t    rd;
    for (int i = 0; i < N_ALU / 2; i++) begin
      f3  = 3'($urandom);
      alt = ((f3 == 3'd0) || (f3 == 3'd5)) && ($urandom % 2 == 1);
      // every 16th result goes to x0
      rd  = (i % 16 == 0) ? 5'd0 : reg_idx_t'($urandom);
      run_instr($sformatf("alu_rr_%0d", i),
                enc_r(alt ? 7'h20 : 7'h00, reg_idx_t'($urandom), reg_idx_t'($urandom), f3, rd,
                      `RV_OPC_OP));
      f3  = 3'($urandom);
      alt = ($urandom % 2 == 1);
      sh  = (i % 10 == 0) ? 6'd63 : 6'($urandom);
      if (f3 == 3'd1) begin
        imm = {6'b000000, sh};
      end else if (f3 == 3'd5) begin
        imm = {alt ? 6'b010000 : 6'b000000, sh};
      end else begin
        imm = 12'($urandom);
      end
      run_instr($sformatf("alu_ri_%0d", i),
                enc_i(imm, reg_idx_t'($urandom), f3, rd, `RV_OPC_OPIMM));
    end
  endtask

  task automatic test_upper();
    for (int i = 0; i < N_UPPER / 2; i++) begin
      run_instr($sformatf("lui_%0d", i), {20'($urandom), reg_idx_t'($urandom), `RV_OPC_LUI});
      run_instr($sformatf("auipc_%0d", i),
                {20'($urandom), reg_idx_t'($urandom), `RV_OPC_AUIPC});
    end
  endtask

  task automatic test_branches();
    // pairs: equal, signed-less, unsigned-less but signed-greater, greater
    reg_idx_t   rs1_sel [4] = '{5'd1, 5'd3, 5'd1, 5'd4};
    reg_idx_t   rs2_sel [4] = '{5'd2, 5'd1, 5'd3, 5'd1};
    logic [2:0] f3_sel [6]  = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    run_instr("br_set_x1", enc_i(12'd5, 5'd0, 3'd0, 5'd1, `RV_OPC_OPIMM));
    run_instr("br_set_x2", enc_i(12'd5, 5'd0, 3'd0, 5'd2, `RV_OPC_OPIMM));
    run_instr("br_set_x3", enc_i(12'hffd, 5'd0, 3'd0, 5'd3, `RV_OPC_OPIMM));
    run_instr("br_set_x4", enc_i(12'd7, 5'd0, 3'd0, 5'd4, `RV_OPC_OPIMM));
    for (int f = 0; f < 6; f++) begin
      for (int p = 0; p < 4; p++) begin
        run_instr($sformatf("branch_f3_%0d_pair_%0d", f3_sel[f], p),
                  enc_b(13'($urandom) & 13'h1ffe, rs2_sel[p], rs1_sel[p], f3_sel[f]));
      end
    end
  endtask

  task automatic test_jumps();
    for (int i = 0; i < N_JMP / 2; i++) begin
      run_instr($sformatf("jal_%0d", i),
                enc_j(21'($urandom) & 21'h1ffffe, reg_idx_t'(($urandom % 31) + 1)));
      // odd offsets exercise the cleared bit 0
      run_instr($sformatf("jalr_%0d", i),
                enc_i(12'($urandom) | 12'd1, reg_idx_t'($urandom), 3'd0,
                      reg_idx_t'(($urandom % 31) + 1), `RV_OPC_JALR));
    end
  endtask

  task automatic test_traps();
    instr_t   ins;
    reg_idx_t rd;
    for (int i = 0; i < N_TRAP / 2; i++) begin
      if (i < 4) begin
        ins = `RV_INSTR_EBREAK;
      end else if (i % 3 == 0) begin
        ins = {25'($urandom), 7'b0000011};
      end else if (i % 3 == 1) begin
        ins = {25'($urandom), 7'b0100011};
      end else begin
        ins = enc_r(7'h01, reg_idx_t'($urandom), reg_idx_t'($urandom), 3'($urandom),
                    reg_idx_t'($urandom), `RV_OPC_OP);
      end
      run_instr($sformatf("trap_%0d", i), ins);
      // read back the register a trapped write would have hit
      rd = (ins[11:7] == 5'd0) ? 5'd1 : ins[11:7];
      run_instr($sformatf("trap_read_%0d", i), enc_r(7'h00, 5'd0, rd, 3'd6, rd, `RV_OPC_OP));
    end
  endtask

  // compares queued reports one edge after capture
  always @(posedge clk) begin
    while (act_q.size() != 0) begin
      cmp_exp  = exp_q.pop_front();
      cmp_act  = act_q.pop_front();
      cmp_name = name_q.pop_front();
      check_xlen(cmp_name, "pc", cmp_exp.pc, cmp_act.pc);
      check_idx(cmp_name, "rd", cmp_exp.rd, cmp_act.rd);
      check_bit(cmp_name, "rd_we", cmp_exp.rd_we, cmp_act.rd_we);
      check_xlen(cmp_name, "rd_data", cmp_exp.rd_data, cmp_act.rd_data);
      check_xlen(cmp_name, "next_pc", cmp_exp.next_pc, cmp_act.next_pc);
      check_trap(cmp_name, "trap", cmp_exp.trap, cmp_act.trap);
    end
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("timeout: req/ack handshake did not complete within %0d cycles",
                          TIMEOUT_CYCLES));
    end
  end

  initial begin
    rst_n = 1'b0;
    req   = 1'b0;
    instr = '0;
    void'($urandom(32'h20bfd76b));
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    model_pc = `RV_RESET_PC;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_bit("reset_state", "ack_o", 1'b0, ack);
    test_reset_state();
    test_seed_regs();
    test_alu();
    test_upper();
    test_branches();
    test_jumps();
    test_traps();
    repeat (2) @(posedge clk);
    #1;
    if (act_q.size() == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      abort_run("retire reports were left without a comparison");
    end
  end

endmodule

// ==== rv_exec_top.sv ====
`timescale 1ns/1ps

module rv_exec_top (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 req_i,
  input  rv_exec_pkg::instr_t  instr_i,
  output logic                 ack_o,
  output rv_exec_pkg::retire_t retire_o
);
  import rv_exec_pkg::*;

  xlen_t    pc;
  reg_idx_t raddr1;
  reg_idx_t raddr2;
  xlen_t    rdata1;
  xlen_t    rdata2;
  exu_req_t exu_req;
  exu_res_t exu_res;
  trap_e    trap;
  logic     we;
  reg_idx_t waddr;
  xlen_t    wdata;

  rv_issue_ctrl u_rv_issue_ctrl (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .req_i     (req_i),
    .exu_res_i (exu_res),
    .trap_i    (trap),
    .ack_o     (ack_o),
    .pc_o      (pc),
    .we_o      (we),
    .waddr_o   (waddr),
    .wdata_o   (wdata),
    .retire_o  (retire_o)
  );

  rv_idu u_rv_idu (
    .instr_i  (instr_i),
    .pc_i     (pc),
    .rdata1_i (rdata1),
    .rdata2_i (rdata2),
    .raddr1_o (raddr1),
    .raddr2_o (raddr2),
    .req_o    (exu_req),
    .trap_o   (trap)
  );

  rv_exu u_rv_exu (
    .req_i (exu_req),
    .res_o (exu_res)
  );

  rv_regfile u_rv_regfile (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .raddr1_i (raddr1),
    .raddr2_i (raddr2),
    .we_i     (we),
    .waddr_i  (waddr),
    .wdata_i  (wdata),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2)
  );

endmodule

// ==== rv_exu.sv ====
`timescale 1ns/1ps
`include "rv_exec_defines.svh"

module rv_exu (
  input  rv_exec_pkg::exu_req_t req_i,
  output rv_exec_pkg::exu_res_t res_o
);
  import rv_exec_pkg::*;

  logic              alu_req;
  logic              op_add, op_sub, op_sll, op_slt, op_sltu, op_xor;
  logic              op_srl, op_sra, op_or, op_and, op_pass;
  logic              op_jal, op_jalr, op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu;
  logic              cmp_unsigned;
  logic              adder_sub;
  logic [`RV_XLEN:0] adder_in1;
  logic [`RV_XLEN:0] adder_in2;
  logic [`RV_XLEN:0] adder_res;
  logic              lt;
  logic              eq;
  logic [5:0]        shamt;
  xlen_t             jump_sum;

  assign alu_req = (req_i.bjp_op == bjp_none);

  // alu decode
  assign op_add  = alu_req && (req_i.alu_op == alu_add);
  assign op_sub  = alu_req && (req_i.alu_op == alu_sub);
  assign op_sll  = alu_req && (req_i.alu_op == alu_sll);
  assign op_slt  = alu_req && (req_i.alu_op == alu_slt);
  assign op_sltu = alu_req && (req_i.alu_op == alu_sltu);
  assign op_xor  = alu_req && (req_i.alu_op == alu_xor);
  assign op_srl  = alu_req && (req_i.alu_op == alu_srl);
  assign op_sra  = alu_req && (req_i.alu_op == alu_sra);
  assign op_or   = alu_req && (req_i.alu_op == alu_or);
  assign op_and  = alu_req && (req_i.alu_op == alu_and);
  assign op_pass = alu_req && (req_i.alu_op == alu_pass_op2);

  // branch and jump decode
  assign op_jal  = (req_i.bjp_op == bjp_jal);
  assign op_jalr = (req_i.bjp_op == bjp_jalr);
  assign op_beq  = (req_i.bjp_op == bjp_beq);
  assign op_bne  = (req_i.bjp_op == bjp_bne);
  assign op_blt  = (req_i.bjp_op == bjp_blt);
  assign op_bge  = (req_i.bjp_op == bjp_bge);
  assign op_bltu = (req_i.bjp_op == bjp_bltu);
  assign op_bgeu = (req_i.bjp_op == bjp_bgeu);

  // one 65-bit adder, zero extension for the unsigned compares
  assign cmp_unsigned = op_sltu | op_bltu | op_bgeu;
  assign adder_sub    = op_sub | op_slt | op_sltu | op_beq | op_bne | op_blt | op_bge
                      | op_bltu | op_bgeu;
  assign adder_in1 = {req_i.op1[`RV_XLEN-1] & ~cmp_unsigned, req_i.op1};
  assign adder_in2 = {req_i.op2[`RV_XLEN-1] & ~cmp_unsigned, req_i.op2};
  assign adder_res = adder_in1 + (adder_sub ? ~adder_in2 : adder_in2)
                   + {{`RV_XLEN{1'b0}}, adder_sub};

  // sign of the exact difference
  assign lt = adder_res[`RV_XLEN];
  assign eq = (adder_res == '0);

  assign shamt    = req_i.op2[5:0];
  assign jump_sum = req_i.jp_op1 + req_i.jp_op2;

  always_comb begin
    res_o.rd      = req_i.rd;
    res_o.rd_we   = req_i.rd_we;
    res_o.rd_data = ({`RV_XLEN{op_add | op_sub}} & adder_res[`RV_XLEN-1:0])
                  | ({`RV_XLEN{op_slt | op_sltu}} & xlen_t'(lt))
                  | ({`RV_XLEN{op_sll}} & (req_i.op1 << shamt))
                  | ({`RV_XLEN{op_srl}} & (req_i.op1 >> shamt))
                  | ({`RV_XLEN{op_sra}} & xlen_t'($signed(req_i.op1) >>> shamt))
                  | ({`RV_XLEN{op_xor}} & (req_i.op1 ^ req_i.op2))
                  | ({`RV_XLEN{op_or}} & (req_i.op1 | req_i.op2))
                  | ({`RV_XLEN{op_and}} & (req_i.op1 & req_i.op2))
                  | ({`RV_XLEN{op_pass}} & req_i.op2)
                  | ({`RV_XLEN{op_jal | op_jalr}} & req_i.link_pc);
    res_o.jump_taken = op_jal | op_jalr | (op_beq & eq) | (op_bne & ~eq)
                     | (op_blt & lt) | (op_bge & ~lt) | (op_bltu & lt) | (op_bgeu & ~lt);
    // jalr drops bit 0 of the target
    res_o.jump_addr = op_jalr ? {jump_sum[`RV_XLEN-1:1], 1'b0} : jump_sum;
  end

endmodule

// ==== rv_idu.sv ====
`timescale 1ns/1ps
`include "rv_exec_defines.svh"

module rv_idu (
  input  rv_exec_pkg::instr_t   instr_i,
  input  rv_exec_pkg::xlen_t    pc_i,
  input  rv_exec_pkg::xlen_t    rdata1_i,
  input  rv_exec_pkg::xlen_t    rdata2_i,
  output rv_exec_pkg::reg_idx_t raddr1_o,
  output rv_exec_pkg::reg_idx_t raddr2_o,
  output rv_exec_pkg::exu_req_t req_o,
  output rv_exec_pkg::trap_e    trap_o
);
  import rv_exec_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_idx_t   rd;
  xlen_t      imm_i;
  xlen_t      imm_u;
  xlen_t      imm_j;
  xlen_t      imm_b;
  logic       rd_wr;
  logic       illegal;
  logic       ebreak;

  // shared by OP and OP-IMM, alt picks sub and sra
  function automatic alu_op_e alu_of_f3(input logic [2:0] f3, input logic alt);
    case (f3)
      `RV_F3_ADD:  return alt ? alu_sub : alu_add;
      `RV_F3_SLL:  return alu_sll;
      `RV_F3_SLT:  return alu_slt;
      `RV_F3_SLTU: return alu_sltu;
      `RV_F3_XOR:  return alu_xor;
      `RV_F3_SR:   return alt ? alu_sra : alu_srl;
      `RV_F3_OR:   return alu_or;
      default:     return alu_and;
    endcase
  endfunction

  assign opcode   = instr_i[6:0];
  assign rd       = instr_i[11:7];
  assign funct3   = instr_i[14:12];
  assign funct7   = instr_i[31:25];
  assign raddr1_o = instr_i[19:15];
  assign raddr2_o = instr_i[24:20];

  assign imm_i = {{(`RV_XLEN-12){instr_i[31]}}, instr_i[31:20]};
  assign imm_u = {{(`RV_XLEN-32){instr_i[31]}}, instr_i[31:12], 12'b0};
  assign imm_j = {{(`RV_XLEN-20){instr_i[31]}}, instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};
  assign imm_b = {{(`RV_XLEN-12){instr_i[31]}}, instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};

  always_comb begin
    req_o.alu_op = alu_add;
    req_o.bjp_op = bjp_none;
    req_o.op1    = rdata1_i;
    req_o.op2    = rdata2_i;
    req_o.jp_op1 = pc_i;
    req_o.jp_op2 = imm_b;
    rd_wr        = 1'b0;
    illegal      = 1'b0;
    ebreak       = 1'b0;
    case (opcode)
      `RV_OPC_OP: begin
        rd_wr        = 1'b1;
        req_o.alu_op = alu_of_f3(funct3, funct7[5]);
        if (funct7 == `RV_F7_ALT) begin
          illegal = (funct3 != `RV_F3_ADD) && (funct3 != `RV_F3_SR);
        end else begin
          illegal = (funct7 != `RV_F7_BASE);
        end
      end
      `RV_OPC_OPIMM: begin
        rd_wr        = 1'b1;
        req_o.op2    = imm_i;
        // bit 30 is an immediate bit except for the right shifts
        req_o.alu_op = alu_of_f3(funct3, (funct3 == `RV_F3_SR) && instr_i[30]);
        if (funct3 == `RV_F3_SLL) begin
          illegal = (instr_i[31:26] != 6'b000000);
        end else if (funct3 == `RV_F3_SR) begin
          illegal = (instr_i[31:26] != 6'b000000) && (instr_i[31:26] != 6'b010000);
        end
      end
      `RV_OPC_LUI: begin
        rd_wr        = 1'b1;
        req_o.alu_op = alu_pass_op2;
        req_o.op2    = imm_u;
      end
      `RV_OPC_AUIPC: begin
        rd_wr     = 1'b1;
        req_o.op1 = pc_i;
        req_o.op2 = imm_u;
      end
      `RV_OPC_JAL: begin
        rd_wr        = 1'b1;
        req_o.bjp_op = bjp_jal;
        req_o.jp_op2 = imm_j;
      end
      `RV_OPC_JALR: begin
        rd_wr        = 1'b1;
        req_o.jp_op1 = rdata1_i;
        req_o.jp_op2 = imm_i;
        if (funct3 == 3'b000) begin
          req_o.bjp_op = bjp_jalr;
        end else begin
          illegal = 1'b1;
        end
      end
      `RV_OPC_BRANCH: begin
        case (funct3)
          `RV_F3_BEQ:  req_o.bjp_op = bjp_beq;
          `RV_F3_BNE:  req_o.bjp_op = bjp_bne;
          `RV_F3_BLT:  req_o.bjp_op = bjp_blt;
          `RV_F3_BGE:  req_o.bjp_op = bjp_bge;
          `RV_F3_BLTU: req_o.bjp_op = bjp_bltu;
          `RV_F3_BGEU: req_o.bjp_op = bjp_bgeu;
          default:     illegal = 1'b1;
        endcase
      end
      `RV_OPC_SYSTEM: begin
        // ebreak is the only system encoding taken
        illegal = (instr_i != `RV_INSTR_EBREAK);
        ebreak  = !illegal;
      end
      default: illegal = 1'b1;
    endcase
    req_o.rd      = rd;
    req_o.rd_we   = rd_wr && (rd != '0) && !illegal && !ebreak;
    req_o.link_pc = pc_i + xlen_t'(4);
  end

  assign trap_o = illegal ? trap_illegal : (ebreak ? trap_ebreak : trap_none);

endmodule

// ==== rv_issue_ctrl.sv ====
`timescale 1ns/1ps
`include "rv_exec_defines.svh"

module rv_issue_ctrl (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  req_i,
  input  rv_exec_pkg::exu_res_t exu_res_i,
  input  rv_exec_pkg::trap_e    trap_i,
  output logic                  ack_o,
  output rv_exec_pkg::xlen_t    pc_o,
  output logic                  we_o,
  output rv_exec_pkg::reg_idx_t waddr_o,
  output rv_exec_pkg::xlen_t    wdata_o,
  output rv_exec_pkg::retire_t  retire_o
);
  import rv_exec_pkg::*;

  ctrl_state_e state_q;
  xlen_t       pc_q;
  xlen_t       next_pc;
  logic        commit;

  // one commit per request, in the idle cycle that sees req high
  assign commit  = (state_q == ctrl_idle) && req_i;
  assign next_pc = (exu_res_i.jump_taken && (trap_i == trap_none)) ? exu_res_i.jump_addr
                                                                   : pc_q + xlen_t'(4);

  assign we_o    = commit && exu_res_i.rd_we;
  assign waddr_o = exu_res_i.rd;
  assign wdata_o = exu_res_i.rd_data;
  assign ack_o   = (state_q == ctrl_ack);
  assign pc_o    = pc_q;

  // four-phase handshake
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= ctrl_idle;
    end else begin
      case (state_q)
        ctrl_idle: begin
          if (req_i) begin
            state_q <= ctrl_ack;
          end
        end
        default: begin
          if (!req_i) begin
            state_q <= ctrl_idle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      pc_q     <= `RV_RESET_PC;
      retire_o <= '0;
    end else if (commit) begin
      pc_q             <= next_pc;
      retire_o.pc      <= pc_q;
      retire_o.rd      <= exu_res_i.rd;
      retire_o.rd_we   <= exu_res_i.rd_we;
      retire_o.rd_data <= exu_res_i.rd_we ? exu_res_i.rd_data : '0;
      retire_o.next_pc <= next_pc;
      retire_o.trap    <= trap_i;
    end
  end

endmodule

// ==== rv_regfile.sv ====
`timescale 1ns/1ps
`include "rv_exec_defines.svh"

module rv_regfile (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  rv_exec_pkg::reg_idx_t raddr1_i,
  input  rv_exec_pkg::reg_idx_t raddr2_i,
  input  logic                  we_i,
  input  rv_exec_pkg::reg_idx_t waddr_i,
  input  rv_exec_pkg::xlen_t    wdata_i,
  output rv_exec_pkg::xlen_t    rdata1_o,
  output rv_exec_pkg::xlen_t    rdata2_o
);
  import rv_exec_pkg::*;

  // x1..x31 only, x0 has no storage
  xlen_t regs [1:`RV_NREG-1];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int i = 1; i < `RV_NREG; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // combinational reads, x0 reads as zero
  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// ==== src.f ====
+incdir+.
rv_exec_pkg.sv
rv_regfile.sv
rv_idu.sv
rv_exu.sv
rv_issue_ctrl.sv
rv_exec_top.sv
tb_clkgen.sv
rv_exec_chk.sv
rv_exec_tb.sv

// ==== tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen (
  output logic clk_o
);

  // 4 ns period
  localparam realtime HALF_PERIOD = 2ns;

  initial begin
    clk_o = 1'b0;
  end

  always #(HALF_PERIOD) clk_o = ~clk_o;

endmodule
